//--- common/enigma_pkg.sv
// enigma cipher shared definitions
// symbol and rotor sizes plus the rotor step types

package enigma_pkg;

	// ==================================================
	// sizes
	// ==================================================

	// one symbol is also a rotor index
	localparam int SYMBOL_W = 6;

	// entries per rotor, one per symbol value
	localparam int ROTOR_DEPTH = 64;

	// rotor B permutes inside groups of this size
	localparam int PERM_GROUP = 8;

	// a full load burst fills rotor A and then rotor B
	localparam int LOAD_LEN = 2 * ROTOR_DEPTH;

	// ==================================================
	// types
	// ==================================================

	typedef logic [SYMBOL_W-1:0] symbol_t;

	// rotor A rotate amount, 0 to 3 places
	typedef logic [1:0] shift_t;

	// rotor B permutation pattern
	typedef logic [$clog2(PERM_GROUP)-1:0] perm_t;

endpackage

//--- source/enigma_loader.sv
// enigma input stage
// registers strobes and data, captures the cipher mode, steers load symbols

`timescale 1ns/1ps

module enigma_loader (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_valid,
	input  logic              in_valid_2,
	input  logic              crypt_mode,
	input  enigma_pkg::symbol_t code_in,
	output logic              load_a,
	output logic              load_b,
	output enigma_pkg::symbol_t load_data,
	output logic              code_valid,
	output enigma_pkg::symbol_t code,
	output logic              decrypt
);

	import enigma_pkg::*;

	logic                        in_valid_q;
	symbol_t                     data_q;
	logic [$clog2(LOAD_LEN)-1:0] load_cnt;

	// strobes and mode
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			in_valid_q <= 1'b0;
			code_valid <= 1'b0;
			decrypt    <= 1'b0;
		end else begin
			in_valid_q <= in_valid;
			code_valid <= in_valid_2;
			// mode is only valid on the first cycle of the load burst
			if (in_valid && !in_valid_q) begin
				decrypt <= crypt_mode;
			end
		end
	end

	// shared data register for rotor and code symbols
	always_ff @(posedge clk) begin
		data_q <= code_in;
	end

	// position inside the load burst, cleared between bursts
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			load_cnt <= '0;
		end else if (in_valid_q) begin
			load_cnt <= load_cnt + 1'b1;
		end else begin
			load_cnt <= '0;
		end
	end

	// first half of the burst goes to rotor A
	assign load_a    = in_valid_q && (load_cnt < ROTOR_DEPTH);
	assign load_b    = in_valid_q && (load_cnt >= ROTOR_DEPTH);
	assign load_data = data_q;
	assign code      = data_q;

endmodule

//--- rotor/rotor_a.sv
// enigma rotor A
// 64-entry rotor with shift-in load, forward and inverse lookup, rotating step

`timescale 1ns/1ps

module rotor_a (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                load,
	input  enigma_pkg::symbol_t load_data,
	input  logic                step,
	input  enigma_pkg::shift_t  shift,
	input  enigma_pkg::symbol_t fwd_in,
	output enigma_pkg::symbol_t fwd_out,
	input  enigma_pkg::symbol_t inv_in,
	output enigma_pkg::symbol_t inv_out
);

	import enigma_pkg::*;

	symbol_t rot     [ROTOR_DEPTH];
	symbol_t rot_nxt [ROTOR_DEPTH];

	// ==================================================
	// next rotor state
	// ==================================================

	always_comb begin
		rot_nxt = rot;
		if (load) begin
			// shift toward index 0, new symbol enters at the top
			for (int i = 0; i < ROTOR_DEPTH - 1; i++) begin
				rot_nxt[i] = rot[i + 1];
			end
			rot_nxt[ROTOR_DEPTH - 1] = load_data;
		end else if (step) begin
			// rotate right, index wraps modulo 64
			for (int i = 0; i < ROTOR_DEPTH; i++) begin
				rot_nxt[i] = rot[symbol_t'(i - int'(shift))];
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < ROTOR_DEPTH; i++) begin
				rot[i] <= '0;
			end
		end else begin
			rot <= rot_nxt;
		end
	end

	// ==================================================
	// lookups
	// ==================================================

	assign fwd_out = rot[fwd_in];

	// inverse search, highest matching index wins
	always_comb begin
		inv_out = '0;
		for (int i = 0; i < ROTOR_DEPTH; i++) begin
			if (rot[i] == inv_in) begin
				inv_out = symbol_t'(i);
			end
		end
	end

endmodule

//--- rotor/rotor_b.sv
// enigma rotor B
// 64-entry rotor with shift-in load, forward and inverse lookup, group permute step

`timescale 1ns/1ps

module rotor_b (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                load,
	input  enigma_pkg::symbol_t load_data,
	input  logic                step,
	input  enigma_pkg::perm_t   pattern,
	input  enigma_pkg::symbol_t fwd_in,
	output enigma_pkg::symbol_t fwd_out,
	input  enigma_pkg::symbol_t inv_in,
	output enigma_pkg::symbol_t inv_out
);

	import enigma_pkg::*;

	localparam int GROUPS = ROTOR_DEPTH / PERM_GROUP;

	symbol_t rot     [ROTOR_DEPTH];
	symbol_t rot_nxt [ROTOR_DEPTH];

	// old position inside a group that fills new position pos
	function automatic perm_t perm_src(input perm_t pat, input perm_t pos);
		perm_t row [PERM_GROUP];
		case (pat)
			3'd0: row = '{3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd6, 3'd7};
			3'd1: row = '{3'd1, 3'd0, 3'd3, 3'd2, 3'd5, 3'd4, 3'd7, 3'd6};
			3'd2: row = '{3'd2, 3'd3, 3'd0, 3'd1, 3'd6, 3'd7, 3'd4, 3'd5};
			3'd3: row = '{3'd0, 3'd4, 3'd5, 3'd6, 3'd1, 3'd2, 3'd3, 3'd7};
			3'd4: row = '{3'd4, 3'd5, 3'd6, 3'd7, 3'd0, 3'd1, 3'd2, 3'd3};
			3'd5: row = '{3'd5, 3'd6, 3'd7, 3'd3, 3'd4, 3'd0, 3'd1, 3'd2};
			3'd6: row = '{3'd6, 3'd7, 3'd3, 3'd2, 3'd5, 3'd4, 3'd0, 3'd1};
			default: row = '{3'd7, 3'd6, 3'd5, 3'd4, 3'd3, 3'd2, 3'd1, 3'd0};
		endcase
		return row[pos];
	endfunction

	// ==================================================
	// next rotor state
	// ==================================================

	always_comb begin
		rot_nxt = rot;
		if (load) begin
			// same shift-in as rotor A
			for (int i = 0; i < ROTOR_DEPTH - 1; i++) begin
				rot_nxt[i] = rot[i + 1];
			end
			rot_nxt[ROTOR_DEPTH - 1] = load_data;
		end else if (step) begin
			// every group of 8 is rebuilt by the same pattern
			for (int g = 0; g < GROUPS; g++) begin
				for (int p = 0; p < PERM_GROUP; p++) begin
					rot_nxt[g * PERM_GROUP + p] =
						rot[g * PERM_GROUP + int'(perm_src(pattern, perm_t'(p)))];
				end
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < ROTOR_DEPTH; i++) begin
				rot[i] <= '0;
			end
		end else begin
			rot <= rot_nxt;
		end
	end

	// ==================================================
	// lookups
	// ==================================================

	assign fwd_out = rot[fwd_in];

	// highest matching index, also when entries repeat
	always_comb begin
		inv_out = '0;
		for (int i = 0; i < ROTOR_DEPTH; i++) begin
			if (rot[i] == inv_in) begin
				inv_out = symbol_t'(i);
			end
		end
	end

endmodule

//--- source/enigma_reflector.sv
// enigma reflector and output stage
// inverts the forward result, picks the rotor step amounts, registers the output

`timescale 1ns/1ps

module enigma_reflector (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                code_valid,
	input  logic                decrypt,
	input  enigma_pkg::symbol_t a_fwd,
	input  enigma_pkg::symbol_t b_fwd,
	input  enigma_pkg::symbol_t b_inv,
	input  enigma_pkg::symbol_t a_inv,
	output enigma_pkg::symbol_t reflected,
	output logic                step,
	output enigma_pkg::shift_t  step_a,
	output enigma_pkg::perm_t   step_b,
	output logic                out_valid,
	output enigma_pkg::symbol_t out_code
);

	import enigma_pkg::*;

	assign reflected = ~b_fwd;

	// both rotors advance after every code symbol
	assign step = code_valid;

	// decrypt takes the step from the return path so it mirrors encrypt
	always_comb begin
		if (decrypt) begin
			step_a = shift_t'(b_inv);
			step_b = perm_t'(reflected);
		end else begin
			step_a = shift_t'(a_fwd);
			step_b = perm_t'(b_fwd);
		end
	end

	// output register, zero between symbols
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			out_code  <= '0;
		end else begin
			out_valid <= code_valid;
			out_code  <= code_valid ? a_inv : symbol_t'(0);
		end
	end

endmodule

//--- source/enigma_top.sv
// enigma cipher top level
// two-rotor 64-symbol cipher with rotor load and encrypt/decrypt stepping

`timescale 1ns/1ps

module enigma_top (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                in_valid,
	input  logic                in_valid_2,
	input  logic                crypt_mode,
	input  enigma_pkg::symbol_t code_in,
	output logic                out_valid,
	output enigma_pkg::symbol_t out_code
);

	import enigma_pkg::*;

	// loader outputs
	logic    load_a;
	logic    load_b;
	symbol_t load_data;
	logic    code_valid;
	symbol_t code;
	logic    decrypt;

	// cipher path
	symbol_t a_fwd;
	symbol_t b_fwd;
	symbol_t reflected;
	symbol_t b_inv;
	symbol_t a_inv;

	// rotor stepping
	logic    step;
	shift_t  step_a;
	perm_t   step_b;

	enigma_loader enigma_loader_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_valid_2 (in_valid_2),
		.crypt_mode (crypt_mode),
		.code_in    (code_in),
		.load_a     (load_a),
		.load_b     (load_b),
		.load_data  (load_data),
		.code_valid (code_valid),
		.code       (code),
		.decrypt    (decrypt)
	);

	// forward A then B, return through B inverse then A inverse
	rotor_a rotor_a_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.load      (load_a),
		.load_data (load_data),
		.step      (step),
		.shift     (step_a),
		.fwd_in    (code),
		.fwd_out   (a_fwd),
		.inv_in    (b_inv),
		.inv_out   (a_inv)
	);

	rotor_b rotor_b_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.load      (load_b),
		.load_data (load_data),
		.step      (step),
		.pattern   (step_b),
		.fwd_in    (a_fwd),
		.fwd_out   (b_fwd),
		.inv_in    (reflected),
		.inv_out   (b_inv)
	);

	enigma_reflector enigma_reflector_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.code_valid (code_valid),
		.decrypt    (decrypt),
		.a_fwd      (a_fwd),
		.b_fwd      (b_fwd),
		.b_inv      (b_inv),
		.a_inv      (a_inv),
		.reflected  (reflected),
		.step       (step),
		.step_a     (step_a),
		.step_b     (step_b),
		.out_valid  (out_valid),
		.out_code   (out_code)
	);

endmodule

//--- tb/enigma_properties.sv
// enigma top-level port properties
// output latency, idle output value and strobe exclusivity

`timescale 1ns/1ps

module enigma_properties (
	input logic                clk,
	input logic                rst_n,
	input logic                in_valid,
	input logic                in_valid_2,
	input logic                out_valid,
	input enigma_pkg::symbol_t out_code
);

	// fixed two-cycle output latency
	property out_latency;
		@(posedge clk) disable iff (!rst_n)
		out_valid == $past(in_valid_2, 2);
	endproperty

	// output is zero between symbols
	property out_zero_idle;
		@(posedge clk) disable iff (!rst_n)
		!out_valid |-> (out_code == '0);
	endproperty

	property strobes_exclusive;
		@(posedge clk) disable iff (!rst_n)
		!(in_valid && in_valid_2);
	endproperty

	assert property (out_latency)
		else $error("out_valid does not follow in_valid_2 by two cycles");
	assert property (out_zero_idle)
		else $error("out_code not zero while out_valid is low");
	assert property (strobes_exclusive)
		else $error("in_valid and in_valid_2 high together");

endmodule

bind enigma_top enigma_properties enigma_properties_inst (
	.clk        (clk),
	.rst_n      (rst_n),
	.in_valid   (in_valid),
	.in_valid_2 (in_valid_2),
	.out_valid  (out_valid),
	.out_code   (out_code)
);

//--- tb/tb_enigma.sv
// enigma cipher testbench
// random rotor loads and code bursts checked against a behavioral model

`timescale 1ns/1ps

module tb_enigma;

	import enigma_pkg::*;

	localparam int CLK_PERIOD  = 4;
	localparam int BURST_LEN   = 40;
	localparam int DRAIN_LIMIT = 8;
	localparam int STIM_CYCLES = 13 + 4 * (LOAD_LEN + 3) + 2 * (BURST_LEN + 8) + 6 * 16 + 50;
	localparam int WATCHDOG_CYCLES = STIM_CYCLES + 200;

	logic    clk = 1'b0;
	logic    rst_n;
	logic    in_valid;
	logic    in_valid_2;
	logic    crypt_mode;
	symbol_t code_in;
	logic    out_valid;
	symbol_t out_code;

	// reference rotors and load stimulus
	symbol_t ma [ROTOR_DEPTH];
	symbol_t mb [ROTOR_DEPTH];
	logic    m_decrypt;
	symbol_t load_seq [LOAD_LEN];

	symbol_t exp_q [$];
	symbol_t plain_q [$];
	symbol_t plain_saved [$];
	symbol_t cipher_saved [$];
	symbol_t exp_code;
	int      errors = 0;
	int      checks = 0;

	enigma_top enigma_top_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_valid_2 (in_valid_2),
		.crypt_mode (crypt_mode),
		.code_in    (code_in),
		.out_valid  (out_valid),
		.out_code   (out_code)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ==================================================
	// reference model
	// ==================================================

	// last index holding v, zero when nothing matches
	function automatic symbol_t find_last(input symbol_t rot[ROTOR_DEPTH], input symbol_t v);
		for (int i = ROTOR_DEPTH - 1; i >= 0; i--) begin
			if (rot[i] == v) begin
				return symbol_t'(i);
			end
		end
		return '0;
	endfunction

	// one nibble per new position, most significant nibble is position 0
	function automatic int perm_source(input perm_t pat, input int pos);
		logic [31:0] row;
		case (pat)
			3'd0: row = 32'h0123_4567;
			3'd1: row = 32'h1032_5476;
			3'd2: row = 32'h2301_6745;
			3'd3: row = 32'h0456_1237;
			3'd4: row = 32'h4567_0123;
			3'd5: row = 32'h5673_4012;
			3'd6: row = 32'h6732_5401;
			default: row = 32'h7654_3210;
		endcase
		return int'((row >> (4 * (7 - pos))) & 32'h7);
	endfunction

	task automatic step_model(input shift_t sa, input perm_t sb);
		symbol_t old_a [ROTOR_DEPTH];
		symbol_t old_b [ROTOR_DEPTH];
		old_a = ma;
		old_b = mb;
		for (int i = 0; i < ROTOR_DEPTH; i++) begin
			ma[(i + int'(sa)) % ROTOR_DEPTH] = old_a[i];
		end
		for (int i = 0; i < ROTOR_DEPTH; i++) begin
			mb[i] = old_b[(i / PERM_GROUP) * PERM_GROUP + perm_source(sb, i % PERM_GROUP)];
		end
	endtask

	// ==================================================
	// stimulus tasks
	// ==================================================

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			in_valid   <= 1'b0;
			in_valid_2 <= 1'b0;
			code_in    <= '0;
		end
	endtask

	// mode only counts on the first cycle, noise elsewhere
	task automatic drive_load(input logic mode);
		for (int i = 0; i < LOAD_LEN; i++) begin
			@(posedge clk);
			in_valid   <= 1'b1;
			in_valid_2 <= 1'b0;
			crypt_mode <= (i == 0) ? mode : 1'($urandom);
			code_in    <= load_seq[i];
		end
		for (int i = 0; i < ROTOR_DEPTH; i++) begin
			ma[i] = load_seq[i];
			mb[i] = load_seq[ROTOR_DEPTH + i];
		end
		m_decrypt = mode;
		idle(3);
	endtask

	task automatic send_symbol(input symbol_t c, output symbol_t res);
		symbol_t a_f;
		symbol_t b_f;
		symbol_t refl;
		symbol_t b_i;
		a_f  = ma[c];
		b_f  = mb[a_f];
		refl = ~b_f;
		b_i  = find_last(mb, refl);
		res  = find_last(ma, b_i);
		if (m_decrypt) begin
			step_model(shift_t'(b_i), perm_t'(refl));
		end else begin
			step_model(shift_t'(a_f), perm_t'(b_f));
		end
		exp_q.push_back(res);
		@(posedge clk);
		in_valid_2 <= 1'b1;
		code_in    <= c;
	endtask

	task automatic make_perm(input int base);
		int      j;
		symbol_t t;
		for (int i = 0; i < ROTOR_DEPTH; i++) begin
			load_seq[base + i] = symbol_t'(i);
		end
		for (int i = ROTOR_DEPTH - 1; i > 0; i--) begin
			j = $urandom_range(i, 0);
			t = load_seq[base + i];
			load_seq[base + i] = load_seq[base + j];
			load_seq[base + j] = t;
		end
	endtask

	// let the pipeline empty, give up after a few cycles
	task automatic wait_drain();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < DRAIN_LIMIT) begin
			idle(1);
			n++;
		end
		idle(2);
	endtask

	// ==================================================
	// output checker, sampled mid-cycle
	// ==================================================

	always @(negedge clk) begin
		if (rst_n && out_valid) begin
			checks++;
			if (exp_q.size() == 0) begin
				$display("ERROR at %0t: out_valid high with no symbol pending", $time);
				errors++;
			end else begin
				exp_code = exp_q.pop_front();
				if (out_code !== exp_code) begin
					$display("MISMATCH at %0t: out_code expected %0d got %0d",
						$time, exp_code, out_code);
					errors++;
				end
			end
			if (plain_q.size() != 0) begin
				exp_code = plain_q.pop_front();
				if (out_code !== exp_code) begin
					$display("MISMATCH at %0t: out_code expected plaintext %0d got %0d",
						$time, exp_code, out_code);
					errors++;
				end
			end
		end else if (rst_n && out_code !== '0) begin
			$display("MISMATCH at %0t: out_code expected 0 got %0d", $time, out_code);
			errors++;
		end
	end

	// ==================================================
	// test sequence
	// ==================================================

	initial begin
		symbol_t p;
		symbol_t c;
		symbol_t v;
		void'($urandom(32'h63c6_5ee3));
		rst_n      = 1'b0;
		in_valid   = 1'b0;
		in_valid_2 = 1'b0;
		crypt_mode = 1'b0;
		code_in    = '0;
		m_decrypt  = 1'b0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;

		// quiet outputs before any code burst
		idle(10);

		// encrypt a burst under random permutations
		make_perm(0);
		make_perm(ROTOR_DEPTH);
		drive_load(1'b0);
		for (int i = 0; i < BURST_LEN; i++) begin
			p = symbol_t'($urandom_range(ROTOR_DEPTH - 1, 0));
			plain_saved.push_back(p);
			send_symbol(p, c);
			cipher_saved.push_back(c);
		end
		wait_drain();

		// same rotors, decrypt the ciphertext
		drive_load(1'b1);
		foreach (cipher_saved[i]) begin
			plain_q.push_back(plain_saved[i]);
			send_symbol(cipher_saved[i], c);
		end
		wait_drain();

		// short bursts with gaps, rotor state must carry over
		make_perm(0);
		make_perm(ROTOR_DEPTH);
		drive_load(1'($urandom));
		for (int b = 0; b < 6; b++) begin
			repeat ($urandom_range(8, 1)) begin
				send_symbol(symbol_t'($urandom_range(ROTOR_DEPTH - 1, 0)), c);
			end
			idle($urandom_range(5, 1));
		end
		wait_drain();

		// repeated entries, inverse takes the highest match
		// small value set closed under inversion so the return path finds matches
		for (int i = 0; i < LOAD_LEN; i++) begin
			v = symbol_t'($urandom_range(7, 0));
			load_seq[i] = ($urandom_range(1, 0) != 0) ? ~v : v;
		end
		drive_load(1'($urandom));
		for (int i = 0; i < 30; i++) begin
			send_symbol(symbol_t'($urandom_range(ROTOR_DEPTH - 1, 0)), c);
		end
		wait_drain();

		if (exp_q.size() != 0) begin
			$display("ERROR: %0d expected symbols never came out", exp_q.size());
			errors++;
		end
		if (plain_q.size() != 0) begin
			$display("ERROR: %0d plaintext symbols were never compared", plain_q.size());
			errors++;
		end
		$display("summary: %0d outputs compared, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Checks failed");
		$finish;
	end

endmodule

//--- files.f
common/enigma_pkg.sv
source/enigma_loader.sv
rotor/rotor_a.sv
rotor/rotor_b.sv
source/enigma_reflector.sv
source/enigma_top.sv
tb/enigma_properties.sv
tb/tb_enigma.sv

//--- Makefile
# Verilator build and run for the enigma cipher testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_enigma \
		-f files.f -o sim_enigma
	./obj_dir/sim_enigma | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
